// File: rtl/csr_pkg.sv
package csr_pkg;

    typedef logic [31:0] word_t;
    typedef logic [13:0] csr_num_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;
    typedef logic [2:0]  plv_ie_t;   // {ie, plv}
    typedef logic [12:0] int_vec_t;  // estat.is / ecfg.lie layout

    typedef enum logic [2:0] {
        OP_NONE,
        OP_CSRRD,
        OP_CSRWR,
        OP_CSRXCHG,
        OP_ERTN,
        OP_EXCP,
        OP_INT      // internal, never issued by the pipeline
    } csr_op_e;

    localparam csr_num_t CSR_CRMD   = 14'h000;
    localparam csr_num_t CSR_PRMD   = 14'h001;
    localparam csr_num_t CSR_ECFG   = 14'h004;
    localparam csr_num_t CSR_ESTAT  = 14'h005;
    localparam csr_num_t CSR_ERA    = 14'h006;
    localparam csr_num_t CSR_EENTRY = 14'h00c;
    localparam csr_num_t CSR_SAVE0  = 14'h030;
    localparam csr_num_t CSR_SAVE1  = 14'h031;
    localparam csr_num_t CSR_SAVE2  = 14'h032;
    localparam csr_num_t CSR_SAVE3  = 14'h033;
    localparam csr_num_t CSR_TID    = 14'h040;
    localparam csr_num_t CSR_TCFG   = 14'h041;
    localparam csr_num_t CSR_TVAL   = 14'h042;
    localparam csr_num_t CSR_TICLR  = 14'h044;

    localparam ecode_t     ECODE_INT  = 6'h00;
    localparam logic [8:0] CRMD_RESET = 9'h008;  // da set

    typedef struct packed {
        logic      valid;
        csr_op_e   op;
        csr_num_t  num;
        word_t     wdata;
        word_t     wmask;
        word_t     pc;
        ecode_t    ecode;
        esubcode_t esubcode;
    } csr_req_t;

    typedef struct packed {
        logic [8:0]      crmd;
        plv_ie_t         prmd;
        int_vec_t        ecfg_lie;
        logic [1:0]      estat_is;
        ecode_t          estat_ecode;
        esubcode_t       estat_esubcode;
        word_t           era;
        logic [25:0]     eentry;
        word_t [3:0]     save;
        word_t           tid;
        word_t           tcfg;
    } csr_view_t;

    typedef struct packed {
        logic      run;
        csr_op_e   op;
        csr_num_t  num;
        word_t     wdata;   // already merged under the xchg mask
        word_t     pc;
        ecode_t    ecode;
        esubcode_t esubcode;
    } csr_commit_t;

    // live interrupt vector built from the estat sw bits and the outside hw and timer lines
    function automatic int_vec_t live_int_vec(logic timer_int, logic [7:0] hw_int,
                                              logic [1:0] sw_int);
        return {1'b0, timer_int, 1'b0, hw_int, sw_int};
    endfunction

endpackage

// File: rtl/csr_issue_ctrl.sv
`timescale 1ns/1ps

module csr_issue_ctrl (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 stall,
    input  logic                 flush,
    input  csr_pkg::csr_req_t    req,
    input  logic [7:0]           hw_int,
    input  logic                 timer_int,
    input  csr_pkg::csr_view_t   view,
    input  csr_pkg::word_t       merged_wdata,
    input  csr_pkg::word_t       read_data,
    output csr_pkg::csr_commit_t commit,
    output csr_pkg::word_t       rdata,
    output logic                 flush_out,
    output logic                 redirect,
    output csr_pkg::word_t       redirect_pc
);
    import csr_pkg::*;

    logic      int_pending;
    logic      take;
    csr_op_e   eff_op;
    ecode_t    eff_ecode;
    esubcode_t eff_esubcode;
    word_t     target_pc;
    logic      is_read;
    logic      is_flush;
    logic      is_redirect;

    assign int_pending = (|(live_int_vec(timer_int, hw_int, view.estat_is) & view.ecfg_lie))
                         && view.crmd[2];
    assign take = req.valid && !flush;

    // a synchronous exception wins over an interrupt
    always_comb
    begin
        eff_op       = req.op;
        eff_ecode    = req.ecode;
        eff_esubcode = req.esubcode;
        if (req.op != OP_EXCP && int_pending)
        begin
            eff_op       = OP_INT;
            eff_ecode    = ECODE_INT;
            eff_esubcode = '0;
        end
    end

    always_comb
    begin
        case (eff_op)
            OP_ERTN:        target_pc = view.era;
            OP_EXCP, OP_INT: target_pc = {view.eentry, 6'b0};
            default:        target_pc = req.pc + 32'd4;
        endcase
    end

    assign is_read     = eff_op inside {OP_CSRRD, OP_CSRWR, OP_CSRXCHG};
    assign is_redirect = eff_op inside {OP_ERTN, OP_EXCP, OP_INT};
    assign is_flush    = is_redirect || (eff_op inside {OP_CSRWR, OP_CSRXCHG});

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            commit.run <= 1'b0;
            flush_out  <= 1'b0;
            redirect   <= 1'b0;
        end
        else if (!stall)
        begin
            commit.run <= take && (eff_op != OP_NONE);  // flush drops the request
            flush_out  <= take && is_flush;
            redirect   <= take && is_redirect;
        end

        if (!stall)
        begin
            commit.op       <= eff_op;
            commit.num      <= req.num;
            commit.wdata    <= merged_wdata;
            commit.pc       <= req.pc;   // becomes era on excp/int
            commit.ecode    <= eff_ecode;
            commit.esubcode <= eff_esubcode;
            rdata           <= (take && is_read) ? read_data : '0;
            redirect_pc     <= target_pc;
        end
    end

endmodule

// File: rtl/csr_timer.sv
`timescale 1ns/1ps

module csr_timer #(
    parameter int TIMER_N = 32
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  csr_pkg::csr_commit_t commit,
    input  csr_pkg::word_t       tcfg,
    input  logic                 stall,
    output csr_pkg::word_t       tval,
    output logic                 timer_int
);
    import csr_pkg::*;

    logic [TIMER_N-1:0] cnt;
    logic [TIMER_N-1:0] init_val;
    logic [TIMER_N-1:0] reload_val;
    logic               wr_csr;
    logic               tcfg_load;
    logic               ticlr_hit;

    assign wr_csr     = commit.run && !stall && (commit.op inside {OP_CSRWR, OP_CSRXCHG});
    assign tcfg_load  = wr_csr && (commit.num == CSR_TCFG) && commit.wdata[0];
    assign ticlr_hit  = wr_csr && (commit.num == CSR_TICLR) && commit.wdata[0];

    // new tcfg comes from the commit, tcfg input still holds the old one
    assign init_val   = {commit.wdata[TIMER_N-1:2], 2'b00};
    assign reload_val = {tcfg[TIMER_N-1:2], 2'b00};
    assign tval       = word_t'(cnt);

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            cnt       <= '0;
            timer_int <= 1'b0;
        end
        else
        begin
            if (ticlr_hit)
                timer_int <= 1'b0;
            else if (tcfg[0] && !tcfg_load && cnt == '0)
                timer_int <= 1'b1;

            if (tcfg_load)
                cnt <= init_val;
            else if (tcfg[0])
            begin
                if (cnt == '0 && tcfg[1])
                    cnt <= reload_val;   // periodic
                else if (cnt != '1)
                    cnt <= cnt - 1'b1;   // one-shot parks at all ones
            end
        end
    end

endmodule

// File: rtl/csr_regfile.sv
`timescale 1ns/1ps

module csr_regfile (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 stall,
    input  csr_pkg::csr_commit_t commit,
    output csr_pkg::csr_view_t   view,
    output logic                 excp_flush,
    output logic                 ertn_flush
);
    import csr_pkg::*;

    logic  fire;
    word_t w;

    assign fire = commit.run && !stall;
    assign w    = commit.wdata;

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            view.crmd           <= CRMD_RESET;
            view.prmd           <= '0;
            view.ecfg_lie       <= '0;
            view.estat_is       <= '0;
            view.estat_ecode    <= '0;
            view.estat_esubcode <= '0;
            view.era            <= '0;
            view.eentry         <= '0;
            view.save           <= '0;
            view.tid            <= '0;
            view.tcfg           <= '0;
            excp_flush          <= 1'b0;
            ertn_flush          <= 1'b0;
        end
        else
        begin
            excp_flush <= fire && (commit.op inside {OP_EXCP, OP_INT});
            ertn_flush <= fire && (commit.op == OP_ERTN);

            if (fire)
            begin
                case (commit.op)
                    OP_ERTN:
                    begin
                        view.crmd[2:0] <= view.prmd;
                    end
                    OP_EXCP, OP_INT:
                    begin
                        view.prmd           <= view.crmd[2:0];
                        view.crmd[2:0]      <= 3'b000;   // plv0, ie off
                        view.era            <= commit.pc;
                        view.estat_ecode    <= commit.ecode;
                        view.estat_esubcode <= commit.esubcode;
                    end
                    OP_CSRWR, OP_CSRXCHG:
                    begin
                        case (commit.num)
                            CSR_CRMD:
                            begin
                                view.crmd[2:0] <= w[2:0];
                                view.crmd[8:5] <= w[8:5];
                                if (w[4] ^ w[3])
                                    view.crmd[4:3] <= w[4:3];  // da/pg only as a valid pair
                            end
                            CSR_PRMD:
                            begin
                                view.prmd <= w[2:0];
                            end
                            CSR_ECFG:
                            begin
                                view.ecfg_lie <= {1'b0, w[11], 1'b0, w[9:0]};
                            end
                            CSR_ESTAT:
                            begin
                                view.estat_is <= w[1:0];   // only sw bits writable
                            end
                            CSR_ERA:
                            begin
                                view.era <= w;
                            end
                            CSR_EENTRY:
                            begin
                                view.eentry <= w[31:6];
                            end
                            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3:
                            begin
                                view.save[commit.num[1:0]] <= w;
                            end
                            CSR_TID:
                            begin
                                view.tid <= w;
                            end
                            CSR_TCFG:
                            begin
                                view.tcfg <= w;
                            end
                            default:
                            begin
                            end
                        endcase
                    end
                    default:
                    begin
                    end
                endcase
            end
        end
    end

endmodule

// File: rtl/csr_read_merge.sv
`timescale 1ns/1ps

module csr_read_merge #(
    parameter int TIMER_N = 32
) (
    input  csr_pkg::csr_num_t  num,
    input  csr_pkg::csr_op_e   op,
    input  csr_pkg::word_t     wdata,
    input  csr_pkg::word_t     wmask,
    input  csr_pkg::csr_view_t view,
    input  csr_pkg::word_t     tval,
    input  logic               timer_int,
    input  logic [7:0]         hw_int,
    output csr_pkg::word_t     read_data,
    output csr_pkg::word_t     merged_wdata
);
    import csr_pkg::*;

    localparam word_t TCFG_MASK = word_t'({TIMER_N{1'b1}});

    word_t wr_mask;

    always_comb
    begin
        case (num)
            CSR_CRMD:   read_data = {23'b0, view.crmd};
            CSR_PRMD:   read_data = {29'b0, view.prmd};
            CSR_ECFG:   read_data = {19'b0, view.ecfg_lie};
            CSR_ESTAT:  read_data = {1'b0, view.estat_esubcode, view.estat_ecode, 3'b0,
                                     live_int_vec(timer_int, hw_int, view.estat_is)};
            CSR_ERA:    read_data = view.era;
            CSR_EENTRY: read_data = {view.eentry, 6'b0};
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3:
                        read_data = view.save[num[1:0]];
            CSR_TID:    read_data = view.tid;
            CSR_TCFG:   read_data = view.tcfg & TCFG_MASK;
            CSR_TVAL:   read_data = tval;
            default:    read_data = '0;   // ticlr and unimplemented numbers
        endcase
    end

    assign wr_mask      = (op == OP_CSRXCHG) ? wmask : '1;
    assign merged_wdata = (read_data & ~wr_mask) | (wdata & wr_mask);

endmodule

// File: rtl/csr_unit.sv
`timescale 1ns/1ps

module csr_unit #(
    parameter int TIMER_N = 32
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               stall,
    input  logic               flush,
    input  csr_pkg::csr_req_t  req,
    input  logic [7:0]         hw_int,
    output csr_pkg::word_t     rdata,
    output logic               flush_out,
    output logic               redirect,
    output csr_pkg::word_t     redirect_pc,
    output logic               excp_flush,
    output logic               ertn_flush
);
    import csr_pkg::*;

    csr_view_t   view;
    csr_commit_t commit;
    word_t       tval;
    word_t       read_data;
    word_t       merged_wdata;
    logic        timer_int;

    csr_issue_ctrl u_issue (
        .clk          (clk),
        .rstn         (rstn),
        .stall        (stall),
        .flush        (flush),
        .req          (req),
        .hw_int       (hw_int),
        .timer_int    (timer_int),
        .view         (view),
        .merged_wdata (merged_wdata),
        .read_data    (read_data),
        .commit       (commit),
        .rdata        (rdata),
        .flush_out    (flush_out),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc)
    );

    csr_timer #(.TIMER_N(TIMER_N)) u_timer (
        .clk       (clk),
        .rstn      (rstn),
        .commit    (commit),
        .tcfg      (view.tcfg),
        .stall     (stall),
        .tval      (tval),
        .timer_int (timer_int)
    );

    csr_regfile u_regfile (
        .clk        (clk),
        .rstn       (rstn),
        .stall      (stall),
        .commit     (commit),
        .view       (view),
        .excp_flush (excp_flush),
        .ertn_flush (ertn_flush)
    );

    csr_read_merge #(.TIMER_N(TIMER_N)) u_read_merge (
        .num          (req.num),
        .op           (req.op),
        .wdata        (req.wdata),
        .wmask        (req.wmask),
        .view         (view),
        .tval         (tval),
        .timer_int    (timer_int),
        .hw_int       (hw_int),
        .read_data    (read_data),
        .merged_wdata (merged_wdata)
    );

endmodule

// File: testbench/tb_csr_model.svh
    // reference copy of the architectural csr state
    csr_view_t mdl;
    logic      mdl_timer;   // estat bit 11

    function automatic void model_reset();
        mdl       = '0;
        mdl.crmd  = CRMD_RESET;
        mdl_timer = 1'b0;
    endfunction

    function automatic word_t ref_read(csr_num_t num);
        word_t r;
        r = '0;
        case (num)
            CSR_CRMD:   r[8:0] = mdl.crmd;
            CSR_PRMD:   r[2:0] = mdl.prmd;
            CSR_ECFG:   r[12:0] = mdl.ecfg_lie;
            CSR_ESTAT:
            begin
                r[1:0]   = mdl.estat_is;
                r[9:2]   = hw_int;
                r[11]    = mdl_timer;
                r[21:16] = mdl.estat_ecode;
                r[30:22] = mdl.estat_esubcode;
            end
            CSR_ERA:    r = mdl.era;
            CSR_EENTRY: r[31:6] = mdl.eentry;
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3:
                        r = mdl.save[num[1:0]];
            CSR_TID:    r = mdl.tid;
            CSR_TCFG:   r = mdl.tcfg;
            default:    r = '0;   // unimplemented reads as zero
        endcase
        return r;
    endfunction

    function automatic word_t ref_redirect_pc(csr_op_e op, word_t pc);
        if (op == OP_ERTN)
            return mdl.era;
        if (op == OP_EXCP || op == OP_INT)
            return {mdl.eentry, 6'b0};
        return pc + 32'd4;
    endfunction

    function automatic void ref_commit(csr_op_e op, csr_num_t num, word_t wdata,
                                       word_t wmask, word_t pc, ecode_t ecode,
                                       esubcode_t esub);
        word_t w;
        w = (op == OP_CSRXCHG) ? ((ref_read(num) & ~wmask) | (wdata & wmask)) : wdata;
        case (op)
            OP_CSRWR, OP_CSRXCHG:
            begin
                case (num)
                    CSR_CRMD:
                    begin
                        mdl.crmd[2:0] = w[2:0];
                        mdl.crmd[8:5] = w[8:5];
                        if (w[4] != w[3])
                            mdl.crmd[4:3] = w[4:3];
                    end
                    CSR_PRMD:   mdl.prmd = w[2:0];
                    CSR_ECFG:   mdl.ecfg_lie = w[12:0] & 13'h0bff;   // bits 10, 12 unused
                    CSR_ESTAT:  mdl.estat_is = w[1:0];
                    CSR_ERA:    mdl.era = w;
                    CSR_EENTRY: mdl.eentry = w[31:6];
                    CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3:
                                mdl.save[num[1:0]] = w;
                    CSR_TID:    mdl.tid = w;
                    CSR_TCFG:   mdl.tcfg = w;
                    CSR_TICLR:  mdl_timer = mdl_timer & ~w[0];
                    default:    ;
                endcase
            end
            OP_EXCP, OP_INT:
            begin
                mdl.prmd           = mdl.crmd[2:0];
                mdl.crmd[2:0]      = 3'b000;
                mdl.era            = pc;
                mdl.estat_ecode    = ecode;
                mdl.estat_esubcode = esub;
            end
            OP_ERTN:    mdl.crmd[2:0] = mdl.prmd;
            default:    ;
        endcase
    endfunction

// File: testbench/tb_csr_unit.sv
`timescale 1ns/1ps

module tb_csr_unit;
    import csr_pkg::*;

    typedef struct packed {
        logic  has_rdata;
        word_t rdata;
        logic  flush_out;
        logic  redirect;
        word_t redirect_pc;
        logic  excp_flush;
        logic  ertn_flush;
    } resp_t;

    logic       clk;
    logic       rstn;
    logic       stall;
    logic       flush;
    csr_req_t   req;
    logic [7:0] hw_int;
    word_t      rdata;
    logic       flush_out;
    logic       redirect;
    word_t      redirect_pc;
    logic       excp_flush;
    logic       ertn_flush;

    resp_t      exp_q[$];
    integer     seed;
    word_t      cur_pc;
    logic       took_int;
    csr_num_t   rw_list [8];

    `include "tb_csr_model.svh"

    csr_unit #(.TIMER_N(32)) UUT (.*);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp)
            stop_on_error($sformatf("Mismatch at %0t: %s expected %h, got %h",
                                    $time, name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            stop_on_error($sformatf("Mismatch at %0t: %s expected %b, got %b",
                                    $time, name, exp, act));
    endtask

    function automatic resp_t expect_resp(csr_op_e op, csr_num_t num, word_t pc);
        resp_t e;
        e.has_rdata   = op inside {OP_CSRRD, OP_CSRWR, OP_CSRXCHG};
        e.rdata       = ref_read(num);
        e.redirect    = op inside {OP_ERTN, OP_EXCP, OP_INT};
        e.flush_out   = e.redirect || (op inside {OP_CSRWR, OP_CSRXCHG});
        e.redirect_pc = ref_redirect_pc(op, pc);
        e.excp_flush  = op inside {OP_EXCP, OP_INT};
        e.ertn_flush  = (op == OP_ERTN);
        return e;
    endfunction

    // one request and its idle slot; hold keeps stall high after the accept
    task automatic issue(input csr_op_e op, input csr_num_t num, input word_t wdata,
                         input word_t wmask, input ecode_t ecode, input esubcode_t esub,
                         input int hold);
        resp_t     e;
        int        i;
        csr_op_e   eff_op;
        ecode_t    eff_ecode;
        esubcode_t eff_esub;
        req.valid    = 1'b1;
        req.op       = op;
        req.num      = num;
        req.wdata    = wdata;
        req.wmask    = wmask;
        req.pc       = cur_pc;
        req.ecode    = ecode;
        req.esubcode = esub;
        @(posedge clk);
        #1;
        req.valid = 1'b0;
        eff_op    = op;
        eff_ecode = ecode;
        eff_esub  = esub;
        if (op == OP_NONE && redirect)
        begin
            eff_op    = OP_INT;   // interrupt taken on an empty slot
            eff_ecode = ECODE_INT;
            eff_esub  = '0;
            took_int  = 1'b1;
        end
        e = expect_resp(eff_op, num, cur_pc);
        ref_commit(eff_op, num, wdata, wmask, cur_pc, eff_ecode, eff_esub);
        exp_q.push_back(e);
        stall = (hold > 0);
        for (i = 0; i < hold; i++)
        begin
            @(posedge clk);
            #1;
            exp_q.push_back(e);   // stage register holds under stall
        end
        stall  = 1'b0;
        cur_pc = cur_pc + 32'd4;
        @(posedge clk);
        #1;
    endtask

    task automatic rd(input csr_num_t num);
        issue(OP_CSRRD, num, '0, '0, '0, '0, 0);
    endtask

    task automatic wr(input csr_num_t num, input word_t d);
        issue(OP_CSRWR, num, d, '0, '0, '0, 0);
    endtask

    // flush pulses land one cycle after the other outputs
    initial
    begin
        resp_t e;
        resp_t prev;
        logic  late;
        late = 1'b0;
        forever
        begin
            @(negedge clk);
            if (late)
            begin
                check_bit("excp_flush", prev.excp_flush, excp_flush);
                check_bit("ertn_flush", prev.ertn_flush, ertn_flush);
            end
            late = 1'b0;
            if (exp_q.size() != 0)
            begin
                e = exp_q.pop_front();
                if (e.has_rdata)
                    check_word("rdata", e.rdata, rdata);
                check_bit("flush_out", e.flush_out, flush_out);
                check_bit("redirect", e.redirect, redirect);
                check_word("redirect_pc", e.redirect_pc, redirect_pc);
                prev = e;
                late = 1'b1;
            end
        end
    end

    initial
    begin
        int    i;
        int    k;
        word_t d;
        word_t msk;
        seed     = 32'h79eb_c1db;
        rstn     = 1'b0;
        stall    = 1'b0;
        flush    = 1'b0;
        hw_int   = '0;
        req      = '0;
        cur_pc   = 32'h1c00_0000;
        took_int = 1'b0;
        rw_list  = '{CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3,
                     CSR_TID, CSR_ERA, CSR_EENTRY, CSR_ECFG};
        model_reset();
        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;

        check_bit("flush_out", 1'b0, flush_out);
        check_bit("redirect", 1'b0, redirect);
        check_bit("excp_flush", 1'b0, excp_flush);
        check_bit("ertn_flush", 1'b0, ertn_flush);
        rd(CSR_CRMD);
        rd(14'h3ff);

        for (i = 0; i < 24; i++)
        begin
            k = $unsigned($random(seed)) % 8;
            d = $random(seed);
            wr(rw_list[k], d);
            rd(rw_list[k]);
        end

        for (i = 0; i < 16; i++)
        begin
            k   = $unsigned($random(seed)) % 8;
            d   = $random(seed);
            msk = $random(seed);
            issue(OP_CSRXCHG, rw_list[k], d, msk, '0, '0, 0);
            rd(rw_list[k]);
        end

        // exception entry and return
        wr(CSR_EENTRY, $random(seed));
        wr(CSR_CRMD, 32'h0000_000f);   // plv3, ie, da
        issue(OP_EXCP, '0, '0, '0, ecode_t'($random(seed)), esubcode_t'($random(seed)), 0);
        rd(CSR_ESTAT);
        rd(CSR_ERA);
        rd(CSR_PRMD);
        rd(CSR_CRMD);
        issue(OP_ERTN, '0, '0, '0, '0, '0, 0);
        rd(CSR_CRMD);

        // one-shot timer interrupt
        wr(CSR_ECFG, 32'h0000_0800);
        wr(CSR_TCFG, 32'h0000_0021);
        i = 0;
        while (!took_int && i < 100)
        begin
            issue(OP_NONE, '0, '0, '0, '0, '0, 0);
            i++;
        end
        if (!took_int)
            stop_on_error("timer interrupt was not taken within 100 requests");
        // 32 timer cycles at two cycles per empty request
        if (i < 17)
            stop_on_error("timer interrupt was taken before the timer could expire");
        mdl_timer = 1'b1;
        rd(CSR_ESTAT);
        rd(CSR_ERA);
        wr(CSR_TICLR, 32'h0000_0001);
        rd(CSR_ESTAT);

        // write held in the commit stage by stall
        d = $random(seed);
        issue(OP_CSRWR, CSR_SAVE1, d, '0, '0, '0, 4);
        rd(CSR_SAVE1);

        for (i = 0; i < 10 && exp_q.size() != 0; i++)
            @(negedge clk);
        if (exp_q.size() != 0)
            stop_on_error("compare queue did not drain after the last request");
        else
        begin
            @(negedge clk);
            #1;
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

// File: compile.f
+incdir+testbench
rtl/csr_pkg.sv
rtl/csr_issue_ctrl.sv
rtl/csr_timer.sv
rtl/csr_regfile.sv
rtl/csr_read_merge.sv
rtl/csr_unit.sv
testbench/tb_csr_unit.sv

// File: run_sim.sh
#!/bin/sh
# build with verilator, run, and pass only if the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_csr_unit \
    -Mdir obj_dir -o sim_csr_unit &&
./obj_dir/sim_csr_unit | tee /dev/stderr | grep -qF ">>> PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
